// File: verilog/vread_pkg.sv
`default_nettype none

package vread_pkg;

   localparam int AXI_DATA_W = 32;
   localparam int ELEM_W     = 16;
   localparam int AXI_ADDR_W = 32;
   localparam int ADDR_W     = 10;
   localparam int WADDR_W    = 9;
   localparam int LEN_W      = 8;
   localparam int APB_ADDR_W = 8;
   localparam int BUF_DEPTH  = 1 << WADDR_W;

   typedef logic [AXI_DATA_W-1:0] bus_word_t;
   typedef logic [ELEM_W-1:0]     elem_t;
   typedef logic [AXI_ADDR_W-1:0] bus_addr_t;
   typedef logic [ADDR_W-1:0]     elem_addr_t;
   typedef logic [LEN_W-1:0]      len_t;

   // two-level loop generator setup
   typedef struct packed {
      elem_addr_t start;
      elem_addr_t incr;
      elem_addr_t shift;
      elem_addr_t per;
      elem_addr_t iter;
   } gen_cfg_t;

   // count is the number of bursts, len the beats per burst
   typedef struct packed {
      bus_addr_t  ext_addr;
      bus_addr_t  addr_shift;
      elem_addr_t count;
      len_t       len;
      logic       read_en;
      logic       ping_pong;
   } rd_cfg_t;

   typedef struct packed {
      logic      valid;
      bus_addr_t addr;
      len_t      len;
   } dbus_req_t;

   typedef struct packed {
      logic      ready;
      bus_word_t rdata;
      logic      last;
   } dbus_rsp_t;

   typedef enum logic {GEN_IDLE, GEN_RUN} gen_state_t;
   typedef enum logic [1:0] {BR_IDLE, BR_REQ, BR_DATA} burst_state_t;

   localparam logic [APB_ADDR_W-1:0] REG_CTRL       = 8'h00;
   localparam logic [APB_ADDR_W-1:0] REG_STATUS     = 8'h04;
   localparam logic [APB_ADDR_W-1:0] REG_EXT_ADDR   = 8'h08;
   localparam logic [APB_ADDR_W-1:0] REG_ADDR_SHIFT = 8'h0C;
   localparam logic [APB_ADDR_W-1:0] REG_COUNT      = 8'h10;
   localparam logic [APB_ADDR_W-1:0] REG_LEN        = 8'h14;
   localparam logic [APB_ADDR_W-1:0] REG_RD_START   = 8'h18;
   localparam logic [APB_ADDR_W-1:0] REG_RD_INCR    = 8'h1C;
   localparam logic [APB_ADDR_W-1:0] REG_RD_PER     = 8'h20;
   localparam logic [APB_ADDR_W-1:0] REG_RD_ITER    = 8'h24;
   localparam logic [APB_ADDR_W-1:0] REG_RD_SHIFT   = 8'h28;
   localparam logic [APB_ADDR_W-1:0] REG_OUT_START  = 8'h2C;
   localparam logic [APB_ADDR_W-1:0] REG_OUT_INCR   = 8'h30;
   localparam logic [APB_ADDR_W-1:0] REG_OUT_PER    = 8'h34;
   localparam logic [APB_ADDR_W-1:0] REG_OUT_ITER   = 8'h38;
   localparam logic [APB_ADDR_W-1:0] REG_OUT_SHIFT  = 8'h3C;

endpackage

`default_nettype wire

// File: verilog/burst_reader.sv
`timescale 1ns/1ps
`default_nettype none

module burst_reader (
   input  wire                  clk,
   input  wire                  rst,
   input  wire                  start_i,
   input  vread_pkg::rd_cfg_t   cfg_i,
   output vread_pkg::dbus_req_t dbus_req_o,
   input  vread_pkg::dbus_rsp_t dbus_rsp_i,
   output logic                 data_valid_o,
   input  wire                  data_ready_i,
   output vread_pkg::bus_word_t data_o,
   output logic                 done_o
);
   import vread_pkg::*;

   burst_state_t state;
   bus_addr_t    burst_addr;
   elem_addr_t   burst_cnt;
   logic         beat;
   logic         last_burst;

   // in the data phase valid acts as the beat enable, so a stalled
   // consumer holds the memory off
   always_comb begin
      dbus_req_o.valid = (state == BR_REQ) || (state == BR_DATA && data_ready_i);
      dbus_req_o.addr  = burst_addr;
      dbus_req_o.len   = cfg_i.len;
   end

   assign beat         = (state == BR_DATA) && data_ready_i && dbus_rsp_i.ready;
   assign data_valid_o = beat;
   assign data_o       = dbus_rsp_i.rdata;
   assign last_burst   = (burst_cnt == elem_addr_t'(cfg_i.count - 1'b1));

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state      <= BR_IDLE;
         burst_addr <= '0;
         burst_cnt  <= '0;
         done_o     <= 1'b1;
      end else begin
         case (state)
            BR_IDLE: begin
               if (start_i) begin
                  burst_addr <= cfg_i.ext_addr;
                  burst_cnt  <= '0;
                  // nothing to fetch means finished at once
                  if (cfg_i.read_en && cfg_i.count != '0) begin
                     state  <= BR_REQ;
                     done_o <= 1'b0;
                  end else begin
                     done_o <= 1'b1;
                  end
               end
            end
            BR_REQ: begin
               if (dbus_rsp_i.ready) begin
                  state <= BR_DATA;
               end
            end
            BR_DATA: begin
               if (beat && dbus_rsp_i.last) begin
                  if (last_burst) begin
                     state  <= BR_IDLE;
                     done_o <= 1'b1;
                  end else begin
                     state      <= BR_REQ;
                     burst_addr <= burst_addr + cfg_i.addr_shift;
                     burst_cnt  <= burst_cnt + 1'b1;
                  end
               end
            end
            default: state <= BR_IDLE;
         endcase
      end
   end

   // a pending request keeps its address until memory takes it
   a_req_stable: assert property (@(posedge clk) disable iff (rst)
      (state == BR_REQ && !dbus_rsp_i.ready)
      |=> (dbus_req_o.valid && $stable(dbus_req_o.addr)));

endmodule

`default_nettype wire

// File: verilog/addr_gen.sv
`timescale 1ns/1ps
`default_nettype none

module addr_gen (
   input  wire                   clk,
   input  wire                   rst,
   input  wire                   run_i,
   input  vread_pkg::gen_cfg_t   cfg_i,
   output logic                  valid_o,
   input  wire                   ready_i,
   output vread_pkg::elem_addr_t addr_o,
   output logic                  done_o
);
   import vread_pkg::*;

   gen_state_t state;
   elem_addr_t inner_cnt;
   elem_addr_t outer_cnt;
   elem_addr_t row_addr;
   logic       accept;
   logic       last_inner;
   logic       last_outer;

   assign valid_o    = (state == GEN_RUN);
   assign accept     = valid_o && ready_i;
   assign last_inner = (inner_cnt == elem_addr_t'(cfg_i.per - 1'b1));
   assign last_outer = (outer_cnt == elem_addr_t'(cfg_i.iter - 1'b1));

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state     <= GEN_IDLE;
         inner_cnt <= '0;
         outer_cnt <= '0;
         row_addr  <= '0;
         addr_o    <= '0;
         done_o    <= 1'b1;
      end else begin
         case (state)
            GEN_IDLE: begin
               if (run_i) begin
                  inner_cnt <= '0;
                  outer_cnt <= '0;
                  row_addr  <= cfg_i.start;
                  addr_o    <= cfg_i.start;
                  // empty loop finishes without emitting
                  if (cfg_i.per != '0 && cfg_i.iter != '0) begin
                     state  <= GEN_RUN;
                     done_o <= 1'b0;
                  end else begin
                     done_o <= 1'b1;
                  end
               end
            end
            GEN_RUN: begin
               if (accept) begin
                  if (last_inner) begin
                     inner_cnt <= '0;
                     if (last_outer) begin
                        state  <= GEN_IDLE;
                        done_o <= 1'b1;
                     end else begin
                        outer_cnt <= outer_cnt + 1'b1;
                        row_addr  <= row_addr + cfg_i.shift;
                        addr_o    <= row_addr + cfg_i.shift;
                     end
                  end else begin
                     inner_cnt <= inner_cnt + 1'b1;
                     addr_o    <= addr_o + cfg_i.incr;
                  end
               end
            end
            default: state <= GEN_IDLE;
         endcase
      end
   end

   // no address appears without a run
   a_idle_quiet: assert property (@(posedge clk) disable iff (rst)
      (state == GEN_IDLE && !run_i) |=> !valid_o);

   // a stalled address holds
   a_hold: assert property (@(posedge clk) disable iff (rst)
      (valid_o && !ready_i) |=> (valid_o && $stable(addr_o)));

endmodule

`default_nettype wire

// File: verilog/handshake_join.sv
`timescale 1ns/1ps
`default_nettype none

module handshake_join (
   input  wire                                  clk,
   input  wire                                  rst,
   input  wire                                  a_valid_i,
   output logic                                 a_ready_o,
   input  wire  [vread_pkg::WADDR_W-1:0]        a_data_i,
   input  wire                                  b_valid_i,
   output logic                                 b_ready_o,
   input  vread_pkg::bus_word_t                 b_data_i,
   output logic                                 wr_en_o,
   output logic [vread_pkg::WADDR_W-1:0]        wr_addr_o,
   output vread_pkg::bus_word_t                 wr_data_o
);
   import vread_pkg::*;

   logic fire;

   // each side waits only on the other, the output never stalls
   assign a_ready_o = b_valid_i;
   assign b_ready_o = a_valid_i;
   assign fire      = a_valid_i && b_valid_i;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         wr_en_o <= 1'b0;
      end else begin
         wr_en_o <= fire;
      end
   end

   always_ff @(posedge clk) begin
      if (fire) begin
         wr_addr_o <= a_data_i;
         wr_data_o <= b_data_i;
      end
   end

endmodule

`default_nettype wire

// File: verilog/dp_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module dp_buffer (
   input  wire                           clk,
   input  wire                           wr_en_i,
   input  wire  [vread_pkg::WADDR_W-1:0] wr_addr_i,
   input  vread_pkg::bus_word_t          wr_data_i,
   input  wire                           rd_en_i,
   input  wire  [vread_pkg::WADDR_W-1:0] rd_addr_i,
   output vread_pkg::bus_word_t          rd_data_o
);
   import vread_pkg::*;

   bus_word_t mem [BUF_DEPTH];

   always_ff @(posedge clk) begin
      if (wr_en_i) begin
         mem[wr_addr_i] <= wr_data_i;
      end
   end

   // one cycle read latency
   always_ff @(posedge clk) begin
      if (rd_en_i) begin
         rd_data_o <= mem[rd_addr_i];
      end
   end

endmodule

`default_nettype wire

// File: verilog/vread_unit.sv
`timescale 1ns/1ps
`default_nettype none

module vread_unit (
   input  wire                  clk,
   input  wire                  rst,
   input  wire                  run_i,
   input  vread_pkg::rd_cfg_t   rd_cfg_i,
   input  vread_pkg::gen_cfg_t  rd_gen_i,
   input  vread_pkg::gen_cfg_t  out_gen_i,
   output vread_pkg::dbus_req_t dbus_req_o,
   input  vread_pkg::dbus_rsp_t dbus_rsp_i,
   output logic                 out_valid_o,
   output vread_pkg::elem_t     out_data_o,
   output logic                 done_o
);
   import vread_pkg::*;

   logic               ping_state;
   logic               data_valid;
   logic               data_ready;
   bus_word_t          data_word;
   logic               rd_done;
   logic               wgen_valid;
   logic               wgen_ready;
   elem_addr_t         wgen_addr;
   logic               wr_bank;
   logic [WADDR_W-1:0] wr_word_addr;
   logic               wr_en;
   logic [WADDR_W-1:0] wr_addr;
   bus_word_t          wr_data;
   logic               ogen_valid;
   elem_addr_t         ogen_addr;
   logic               out_done;
   logic               rd_bank;
   logic [WADDR_W-1:0] rd_word_addr;
   bus_word_t          rd_word;
   logic               half_q;

   // toggles per run in ping-pong mode
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         ping_state <= 1'b0;
      end else if (run_i) begin
         ping_state <= rd_cfg_i.ping_pong ? !ping_state : 1'b0;
      end
   end

   burst_reader u_reader (
      .clk         (clk),
      .rst         (rst),
      .start_i     (run_i),
      .cfg_i       (rd_cfg_i),
      .dbus_req_o  (dbus_req_o),
      .dbus_rsp_i  (dbus_rsp_i),
      .data_valid_o(data_valid),
      .data_ready_i(data_ready),
      .data_o      (data_word),
      .done_o      (rd_done)
   );

   // write side, addresses are buffer words
   addr_gen u_rd_gen (
      .clk    (clk),
      .rst    (rst),
      .run_i  (run_i && rd_cfg_i.read_en),
      .cfg_i  (rd_gen_i),
      .valid_o(wgen_valid),
      .ready_i(wgen_ready),
      .addr_o (wgen_addr),
      .done_o ()
   );

   // ping-pong fills the bank not being drained
   assign wr_bank      = rd_cfg_i.ping_pong ? !ping_state : wgen_addr[WADDR_W-1];
   assign wr_word_addr = {wr_bank, wgen_addr[WADDR_W-2:0]};

   handshake_join u_join (
      .clk      (clk),
      .rst      (rst),
      .a_valid_i(wgen_valid),
      .a_ready_o(wgen_ready),
      .a_data_i (wr_word_addr),
      .b_valid_i(data_valid),
      .b_ready_o(data_ready),
      .b_data_i (data_word),
      .wr_en_o  (wr_en),
      .wr_addr_o(wr_addr),
      .wr_data_o(wr_data)
   );

   // output side, addresses are elements
   addr_gen u_out_gen (
      .clk    (clk),
      .rst    (rst),
      .run_i  (run_i),
      .cfg_i  (out_gen_i),
      .valid_o(ogen_valid),
      .ready_i(1'b1),
      .addr_o (ogen_addr),
      .done_o (out_done)
   );

   // element to word, low bit picks the half
   assign rd_bank      = rd_cfg_i.ping_pong ? ping_state : ogen_addr[ADDR_W-1];
   assign rd_word_addr = {rd_bank, ogen_addr[ADDR_W-2:1]};

   dp_buffer u_buf (
      .clk      (clk),
      .wr_en_i  (wr_en),
      .wr_addr_i(wr_addr),
      .wr_data_i(wr_data),
      .rd_en_i  (ogen_valid),
      .rd_addr_i(rd_word_addr),
      .rd_data_o(rd_word)
   );

   // half select follows the buffer read latency
   always_ff @(posedge clk) begin
      half_q <= ogen_addr[0];
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         out_valid_o <= 1'b0;
      end else begin
         out_valid_o <= ogen_valid;
      end
   end

   assign out_data_o = half_q ? rd_word[AXI_DATA_W-1 -: ELEM_W] : rd_word[ELEM_W-1:0];

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         done_o <= 1'b1;
      end else if (run_i) begin
         done_o <= 1'b0;
      end else if (rd_done && out_done) begin
         done_o <= 1'b1;
      end
   end

   // generated bank bits would be overridden in ping-pong mode
   a_pp_bank: assert property (@(posedge clk) disable iff (rst)
      rd_cfg_i.ping_pong |-> !(wgen_valid && wgen_addr[ADDR_W-1 -: 2] != 2'b00)
                             && !(ogen_valid && ogen_addr[ADDR_W-1]));

endmodule

`default_nettype wire

// File: verilog/vread_cfg_apb.sv
`timescale 1ns/1ps
`default_nettype none

module vread_cfg_apb (
   input  wire                              clk,
   input  wire                              rst,
   input  wire  [vread_pkg::APB_ADDR_W-1:0] paddr_i,
   input  wire                              psel_i,
   input  wire                              penable_i,
   input  wire                              pwrite_i,
   input  vread_pkg::bus_word_t             pwdata_i,
   output vread_pkg::bus_word_t             prdata_o,
   output logic                             pready_o,
   output logic                             pslverr_o,
   output logic                             run_o,
   output vread_pkg::rd_cfg_t               rd_cfg_o,
   output vread_pkg::gen_cfg_t              rd_gen_o,
   output vread_pkg::gen_cfg_t              out_gen_o,
   input  wire                              done_i
);
   import vread_pkg::*;

   logic wr_access;
   logic rd_access;

   assign pready_o  = 1'b1;
   assign pslverr_o = 1'b0;
   assign wr_access = psel_i && penable_i && pwrite_i;
   assign rd_access = psel_i && penable_i && !pwrite_i;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         run_o     <= 1'b0;
         rd_cfg_o  <= '0;
         rd_gen_o  <= '0;
         out_gen_o <= '0;
      end else begin
         // run bit self-clears, pulse lands after the write
         run_o <= wr_access && (paddr_i == REG_CTRL) && pwdata_i[0];
         if (wr_access) begin
            case (paddr_i)
               REG_CTRL: begin
                  rd_cfg_o.read_en   <= pwdata_i[1];
                  rd_cfg_o.ping_pong <= pwdata_i[2];
               end
               REG_EXT_ADDR:   rd_cfg_o.ext_addr   <= pwdata_i;
               REG_ADDR_SHIFT: rd_cfg_o.addr_shift <= pwdata_i;
               REG_COUNT:      rd_cfg_o.count      <= pwdata_i[ADDR_W-1:0];
               REG_LEN:        rd_cfg_o.len        <= pwdata_i[LEN_W-1:0];
               REG_RD_START:   rd_gen_o.start      <= pwdata_i[ADDR_W-1:0];
               REG_RD_INCR:    rd_gen_o.incr       <= pwdata_i[ADDR_W-1:0];
               REG_RD_PER:     rd_gen_o.per        <= pwdata_i[ADDR_W-1:0];
               REG_RD_ITER:    rd_gen_o.iter       <= pwdata_i[ADDR_W-1:0];
               REG_RD_SHIFT:   rd_gen_o.shift      <= pwdata_i[ADDR_W-1:0];
               REG_OUT_START:  out_gen_o.start     <= pwdata_i[ADDR_W-1:0];
               REG_OUT_INCR:   out_gen_o.incr      <= pwdata_i[ADDR_W-1:0];
               REG_OUT_PER:    out_gen_o.per       <= pwdata_i[ADDR_W-1:0];
               REG_OUT_ITER:   out_gen_o.iter      <= pwdata_i[ADDR_W-1:0];
               REG_OUT_SHIFT:  out_gen_o.shift     <= pwdata_i[ADDR_W-1:0];
               default: ;
            endcase
         end
      end
   end

   always_comb begin
      prdata_o = '0;
      if (rd_access) begin
         case (paddr_i)
            REG_CTRL:       prdata_o[2:1]        = {rd_cfg_o.ping_pong, rd_cfg_o.read_en};
            REG_STATUS:     prdata_o[0]          = done_i;
            REG_EXT_ADDR:   prdata_o             = rd_cfg_o.ext_addr;
            REG_ADDR_SHIFT: prdata_o             = rd_cfg_o.addr_shift;
            REG_COUNT:      prdata_o[ADDR_W-1:0] = rd_cfg_o.count;
            REG_LEN:        prdata_o[LEN_W-1:0]  = rd_cfg_o.len;
            REG_RD_START:   prdata_o[ADDR_W-1:0] = rd_gen_o.start;
            REG_RD_INCR:    prdata_o[ADDR_W-1:0] = rd_gen_o.incr;
            REG_RD_PER:     prdata_o[ADDR_W-1:0] = rd_gen_o.per;
            REG_RD_ITER:    prdata_o[ADDR_W-1:0] = rd_gen_o.iter;
            REG_RD_SHIFT:   prdata_o[ADDR_W-1:0] = rd_gen_o.shift;
            REG_OUT_START:  prdata_o[ADDR_W-1:0] = out_gen_o.start;
            REG_OUT_INCR:   prdata_o[ADDR_W-1:0] = out_gen_o.incr;
            REG_OUT_PER:    prdata_o[ADDR_W-1:0] = out_gen_o.per;
            REG_OUT_ITER:   prdata_o[ADDR_W-1:0] = out_gen_o.iter;
            REG_OUT_SHIFT:  prdata_o[ADDR_W-1:0] = out_gen_o.shift;
            default: ;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: verilog/vread_top.sv
`timescale 1ns/1ps
`default_nettype none

module vread_top (
   input  wire                              clk,
   input  wire                              rst,
   input  wire  [vread_pkg::APB_ADDR_W-1:0] paddr_i,
   input  wire                              psel_i,
   input  wire                              penable_i,
   input  wire                              pwrite_i,
   input  vread_pkg::bus_word_t             pwdata_i,
   output vread_pkg::bus_word_t             prdata_o,
   output logic                             pready_o,
   output logic                             pslverr_o,
   output vread_pkg::dbus_req_t             dbus_req_o,
   input  vread_pkg::dbus_rsp_t             dbus_rsp_i,
   output logic                             out_valid_o,
   output vread_pkg::elem_t                 out_data_o
);
   import vread_pkg::*;

   logic     run;
   logic     done;
   rd_cfg_t  rd_cfg;
   gen_cfg_t rd_gen;
   gen_cfg_t out_gen;

   vread_cfg_apb u_cfg (
      .clk      (clk),
      .rst      (rst),
      .paddr_i  (paddr_i),
      .psel_i   (psel_i),
      .penable_i(penable_i),
      .pwrite_i (pwrite_i),
      .pwdata_i (pwdata_i),
      .prdata_o (prdata_o),
      .pready_o (pready_o),
      .pslverr_o(pslverr_o),
      .run_o    (run),
      .rd_cfg_o (rd_cfg),
      .rd_gen_o (rd_gen),
      .out_gen_o(out_gen),
      .done_i   (done)
   );

   vread_unit u_unit (
      .clk        (clk),
      .rst        (rst),
      .run_i      (run),
      .rd_cfg_i   (rd_cfg),
      .rd_gen_i   (rd_gen),
      .out_gen_i  (out_gen),
      .dbus_req_o (dbus_req_o),
      .dbus_rsp_i (dbus_rsp_i),
      .out_valid_o(out_valid_o),
      .out_data_o (out_data_o),
      .done_o     (done)
   );

endmodule

`default_nettype wire

// File: sim/bus_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module bus_mem_model #(
   parameter vread_pkg::bus_addr_t EXP_BASE  = 32'h0,
   parameter vread_pkg::bus_addr_t EXP_SHIFT = 32'h0,
   parameter int unsigned          EXP_LEN   = 1,
   parameter int unsigned          EXP_COUNT = 1,
   parameter vread_pkg::bus_word_t DATA_KEY  = 32'h0
) (
   input  wire                  clk,
   input  wire                  rst,
   input  wire                  stall_i,
   input  vread_pkg::dbus_req_t req_i,
   output vread_pkg::dbus_rsp_t rsp_o,
   output int unsigned          req_count_o,
   output int unsigned          beat_count_o,
   output logic                 error_o
);
   import vread_pkg::*;

   logic      busy;
   bus_addr_t burst_addr;
   len_t      burst_len;
   len_t      beat;
   bus_word_t rdata_q;
   logic      last_q;
   logic      take;
   bus_addr_t exp_addr;

   // ready low is the only stall, valid doubles as the beat enable
   assign rsp_o    = {!stall_i, rdata_q, last_q};
   assign take     = req_i.valid && rsp_o.ready;
   assign exp_addr = EXP_BASE + EXP_SHIFT * bus_addr_t'(req_count_o % EXP_COUNT);

   // beat data for the coming edge
   always @(negedge clk) begin
      rdata_q <= (burst_addr + bus_addr_t'(4 * beat)) ^ DATA_KEY;
      last_q  <= busy && (beat == burst_len - 1'b1);
   end

   always @(posedge clk or posedge rst) begin
      if (rst) begin
         busy         <= 1'b0;
         burst_addr   <= '0;
         burst_len    <= '0;
         beat         <= '0;
         req_count_o  <= 0;
         beat_count_o <= 0;
         error_o      <= 1'b0;
      end else if (!busy) begin
         if (take) begin
            assert (req_i.addr == exp_addr) else begin
               $display("** Error at %0t ns: request %0d at 0x%08h, expected 0x%08h",
                        $time, req_count_o, req_i.addr, exp_addr);
               error_o <= 1'b1;
            end
            assert (req_i.len == len_t'(EXP_LEN)) else begin
               $display("** Error at %0t ns: burst length %0d, expected %0d",
                        $time, req_i.len, EXP_LEN);
               error_o <= 1'b1;
            end
            busy        <= 1'b1;
            burst_addr  <= req_i.addr;
            burst_len   <= req_i.len;
            beat        <= '0;
            req_count_o <= req_count_o + 1;
         end
      end else if (take) begin
         beat_count_o <= beat_count_o + 1;
         beat         <= beat + 1'b1;
         if (beat == burst_len - 1'b1) begin
            busy <= 1'b0;
         end
      end
   end

endmodule

`default_nettype wire

// File: sim/tb_vread_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_vread_top;
   import vread_pkg::*;

   localparam int          CLK_PERIOD   = 8;
   localparam int          RESET_CYCLES = 8;
   // two rounds of two runs, each well under a thousand cycles
   localparam int unsigned MAX_CYCLES   = 20000;
   localparam logic [31:0] SEED         = 32'h2ce5_04d5;
   localparam bus_addr_t   EXT_BASE     = 32'h1000;
   localparam bus_addr_t   EXT_SHIFT    = 32'h40;
   localparam int unsigned BURSTS       = 4;
   localparam int unsigned BEATS        = 8;
   localparam bus_word_t   DATA_KEY     = 32'h5a5a_0000;
   localparam int unsigned OUT_START    = 0;
   localparam int unsigned OUT_INCR     = 1;
   localparam int unsigned OUT_PER      = 16;
   localparam int unsigned OUT_ITER     = 4;
   localparam int unsigned OUT_SHIFT    = 16;
   localparam int unsigned OUT_TOTAL    = OUT_PER * OUT_ITER;

   logic                  clk;
   logic                  rst;
   logic [APB_ADDR_W-1:0] paddr;
   logic                  psel;
   logic                  penable;
   logic                  pwrite;
   bus_word_t             pwdata;
   bus_word_t             prdata;
   logic                  pready;
   logic                  pslverr;
   dbus_req_t             dbus_req;
   dbus_rsp_t             dbus_rsp;
   logic                  out_valid;
   elem_t                 out_data;
   logic                  stall;
   logic                  stall_en;
   logic                  mem_error;
   int unsigned           req_count;
   int unsigned           beat_count;
   int unsigned           cycles = 0;
   int unsigned           out_count = 0;
   logic                  check_en;
   int unsigned           check_base;

   vread_top DUT (
      .clk        (clk),
      .rst        (rst),
      .paddr_i    (paddr),
      .psel_i     (psel),
      .penable_i  (penable),
      .pwrite_i   (pwrite),
      .pwdata_i   (pwdata),
      .prdata_o   (prdata),
      .pready_o   (pready),
      .pslverr_o  (pslverr),
      .dbus_req_o (dbus_req),
      .dbus_rsp_i (dbus_rsp),
      .out_valid_o(out_valid),
      .out_data_o (out_data)
   );

   bus_mem_model #(
      .EXP_BASE (EXT_BASE),
      .EXP_SHIFT(EXT_SHIFT),
      .EXP_LEN  (BEATS),
      .EXP_COUNT(BURSTS),
      .DATA_KEY (DATA_KEY)
   ) u_mem (
      .clk         (clk),
      .rst         (rst),
      .stall_i     (stall),
      .req_i       (dbus_req),
      .rsp_o       (dbus_rsp),
      .req_count_o (req_count),
      .beat_count_o(beat_count),
      .error_o     (mem_error)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // memory stalls roughly one cycle in three when enabled
   initial begin
      void'($urandom(SEED));
      stall = 1'b0;
      forever begin
         @(negedge clk);
         stall = stall_en && ($urandom % 3 == 0);
      end
   end

   task automatic report_error(input string msg);
      $display("** Error at %0t ns: %s", $time, msg);
      $display("Test failed");
      $fatal(1, "stopped at the first error");
   endtask

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
         $display("Test failed");
         $fatal(1, "stopped by the cycle limit");
      end
   end

   // the memory model has already printed its error line
   always @(posedge clk) begin
      if (mem_error) begin
         $display("Test failed");
         $fatal(1, "stopped on a databus request error");
      end
   end

   // element idx of the drain run, from the generator and half rules
   function automatic elem_t predicted_element(input int unsigned idx);
      logic [31:0] elem_addr;
      int unsigned word_addr;
      bus_addr_t   byte_addr;
      bus_word_t   word;
      elem_addr = OUT_START + (idx / OUT_PER) * OUT_SHIFT + (idx % OUT_PER) * OUT_INCR;
      word_addr = elem_addr >> 1;
      // the read generator is linear, so word k holds beat k
      byte_addr = EXT_BASE + bus_addr_t'(word_addr / BEATS) * EXT_SHIFT
                  + bus_addr_t'(4 * (word_addr % BEATS));
      word = byte_addr ^ DATA_KEY;
      return elem_addr[0] ? word[31:16] : word[15:0];
   endfunction

   always @(posedge clk) begin : out_monitor
      int unsigned idx;
      elem_t       exp_elem;
      if (out_valid) begin
         if (check_en) begin
            idx      = out_count - check_base;
            exp_elem = predicted_element(idx);
            assert (idx < OUT_TOTAL)
               else report_error("more output elements than the generator allows");
            assert (out_data == exp_elem)
               else report_error($sformatf("element %0d is 0x%04h, expected 0x%04h",
                                           idx, out_data, exp_elem));
         end
         out_count <= out_count + 1;
      end
   end

   task automatic apb_write(input logic [APB_ADDR_W-1:0] addr, input bus_word_t data);
      @(negedge clk);
      paddr   = addr;
      pwdata  = data;
      pwrite  = 1'b1;
      psel    = 1'b1;
      penable = 1'b0;
      @(negedge clk);
      penable = 1'b1;
      @(posedge clk);
      // zero wait states and no slave error
      assert (pready === 1'b1 && pslverr === 1'b0)
         else report_error($sformatf("APB write to 0x%02h got pready %b pslverr %b",
                                     addr, pready, pslverr));
      @(negedge clk);
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic apb_read(input logic [APB_ADDR_W-1:0] addr, output bus_word_t data);
      @(negedge clk);
      paddr   = addr;
      pwrite  = 1'b0;
      psel    = 1'b1;
      penable = 1'b0;
      @(negedge clk);
      penable = 1'b1;
      @(posedge clk);
      assert (pready === 1'b1 && pslverr === 1'b0)
         else report_error($sformatf("APB read of 0x%02h got pready %b pslverr %b",
                                     addr, pready, pslverr));
      data = prdata;
      @(negedge clk);
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic write_checked(input logic [APB_ADDR_W-1:0] addr, input bus_word_t value);
      bus_word_t rdata;
      apb_write(addr, value);
      apb_read(addr, rdata);
      assert (rdata == value)
         else report_error($sformatf("register 0x%02h reads 0x%08h after writing 0x%08h",
                                     addr, rdata, value));
   endtask

   task automatic wait_done();
      bus_word_t rdata;
      do begin
         apb_read(REG_STATUS, rdata);
      end while (rdata[0] !== 1'b1);
   endtask

   task automatic configure();
      write_checked(REG_EXT_ADDR, EXT_BASE);
      write_checked(REG_ADDR_SHIFT, EXT_SHIFT);
      write_checked(REG_COUNT, BURSTS);
      write_checked(REG_LEN, BEATS);
      // read side writes words 0 .. count*len-1 in order
      write_checked(REG_RD_START, 0);
      write_checked(REG_RD_INCR, 1);
      write_checked(REG_RD_PER, BEATS);
      write_checked(REG_RD_ITER, BURSTS);
      write_checked(REG_RD_SHIFT, BEATS);
      write_checked(REG_OUT_START, OUT_START);
      write_checked(REG_OUT_INCR, OUT_INCR);
      write_checked(REG_OUT_PER, OUT_PER);
      write_checked(REG_OUT_ITER, OUT_ITER);
      write_checked(REG_OUT_SHIFT, OUT_SHIFT);
   endtask

   // fill run into bank 0, then a drain run of bank 0 with no fetch
   task automatic fill_and_drain(input logic with_stalls);
      bus_word_t   rdata;
      int unsigned req_before;
      int unsigned beat_before;
      int unsigned out_before;
      req_before  = req_count;
      beat_before = beat_count;
      out_before  = out_count;
      stall_en    = with_stalls;
      apb_write(REG_CTRL, 32'h7);
      apb_read(REG_STATUS, rdata);
      assert (rdata[0] == 1'b0) else report_error("STATUS done is set during the fill run");
      wait_done();
      stall_en = 1'b0;
      assert (req_count - req_before == BURSTS)
         else report_error($sformatf("%0d bursts requested, expected %0d",
                                     req_count - req_before, BURSTS));
      assert (beat_count - beat_before == BURSTS * BEATS)
         else report_error($sformatf("%0d beats taken, expected %0d",
                                     beat_count - beat_before, BURSTS * BEATS));
      assert (out_count - out_before == OUT_TOTAL)
         else report_error("wrong element count in the fill run");
      out_before = out_count;
      check_base = out_count;
      check_en   = 1'b1;
      apb_write(REG_CTRL, 32'h5);
      wait_done();
      check_en = 1'b0;
      assert (out_count - out_before == OUT_TOTAL)
         else report_error("wrong element count in the drain run");
      assert (req_count == req_before + BURSTS)
         else report_error("the drain run requested data with read_en clear");
   endtask

   initial begin
      bus_word_t rdata;
      rst        = 1'b1;
      paddr      = '0;
      psel       = 1'b0;
      penable    = 1'b0;
      pwrite     = 1'b0;
      pwdata     = '0;
      stall_en   = 1'b0;
      check_en   = 1'b0;
      check_base = 0;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      apb_read(REG_STATUS, rdata);
      assert (rdata[0] == 1'b1) else report_error("STATUS done is clear after reset");
      configure();

      // the stalled round runs first, while bank 0 still holds no data
      fill_and_drain(1'b1);
      fill_and_drain(1'b0);

      $display("Test passed");
      $finish;
   end

endmodule

`default_nettype wire

// File: files.f
verilog/vread_pkg.sv
verilog/burst_reader.sv
verilog/addr_gen.sv
verilog/handshake_join.sv
verilog/dp_buffer.sv
verilog/vread_unit.sv
verilog/vread_cfg_apb.sv
verilog/vread_top.sv
sim/bus_mem_model.sv
sim/tb_vread_top.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_vread_top
FILELIST  = files.f
SIM_BIN   = obj_dir/V$(TOP)

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(SIM_BIN))"; \
	printf '%s\n' "$$out"; \
	printf '%s\n' "$$out" | grep -q "Test passed"

clean:
	rm -rf obj_dir
